// File: flist.f
+incdir+verif
hw/board_uplink_pkg.sv
hw/board_capture.sv
hw/record_framer.sv
hw/uart_tx.sv
hw/board_uplink_top.sv
verif/tb_board_uplink.sv

// File: Bender.yml
package:
  name: board_uplink

sources:
  - files:
      - hw/board_uplink_pkg.sv
      - hw/board_capture.sv
      - hw/record_framer.sv
      - hw/uart_tx.sv
      - hw/board_uplink_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_board_uplink.sv

// File: verif/uart_rx_model.svh
`ifndef UART_RX_MODEL_SVH
`define UART_RX_MODEL_SVH

// Serial line model, included in the testbench module body
// tx is sampled on every falling clock edge, CLKS_PER_BIT samples per bit

task automatic receive_byte(output logic [7:0] data);
    logic [9:0] frame;
    logic       first;
    logic       s;
    int         b;
    int         k;
    @(negedge tx);
    rx_active = 1'b1;
    for (b = 0; b < 10; b++) begin
        first = 1'b0;
        for (k = 0; k < CLKS_PER_BIT; k++) begin
            @(negedge clk);
            s = tx;
            if (k == 0) begin
                first = s;
            end else if (s !== first) begin
                $display("tx changed inside bit %0d of a byte", b);
                errors++;
            end
        end
        frame[b] = first;
    end
    if (frame[0] !== 1'b0) begin
        $display("[FAIL] tx start bit expected %h got %h", 1'b0, frame[0]);
        errors++;
    end
    if (frame[9] !== 1'b1) begin
        $display("[FAIL] tx stop bit expected %h got %h", 1'b1, frame[9]);
        errors++;
    end
    data = frame[8:1]; // LSB first on the line
    rx_active = 1'b0;
endtask

// High byte first, two bytes per record
task automatic collect_records();
    logic [7:0] hi;
    logic [7:0] lo;
    forever begin
        receive_byte(hi);
        byte_count++;
        receive_byte(lo);
        byte_count++;
        rec_q.push_back({hi, lo});
    end
endtask

`endif

// File: verif/tb_board_uplink.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_uplink;

    import board_uplink_pkg::*;

    localparam int CLKS_PER_BIT = 4;
    localparam int CLK_PERIOD = 40;
    localparam int DRV_DELAY = 5;
    localparam int N_ENTRIES = 9;

    typedef enum logic [1:0] {
        PAT_RANDOM,
        PAT_ONES,
        PAT_CHECKER
    } pattern_e;

    typedef struct packed {
        logic [DIM_W-1:0] rows;
        logic [DIM_W-1:0] cols;
        pattern_e         pattern;
        logic             err;     // dim_error expected
        logic             overlap; // Second load while busy
    } entry_t;

    entry_t entries [N_ENTRIES] = '{
        '{4'd1,  4'd1,  PAT_ONES,    1'b0, 1'b0},
        '{4'd3,  4'd5,  PAT_RANDOM,  1'b0, 1'b0},
        '{4'd0,  4'd4,  PAT_RANDOM,  1'b1, 1'b0},
        '{4'd4,  4'd12, PAT_ONES,    1'b1, 1'b0},
        '{4'd2,  4'd3,  PAT_CHECKER, 1'b0, 1'b1},
        '{4'd5,  4'd7,  PAT_RANDOM,  1'b0, 1'b0},
        '{4'd15, 4'd2,  PAT_CHECKER, 1'b1, 1'b0},
        '{4'd2,  4'd0,  PAT_ONES,    1'b1, 1'b0},
        '{4'd11, 4'd11, PAT_RANDOM,  1'b0, 1'b0}
    };

    logic                            clk;
    logic                            rst;
    logic                            load;
    logic [MAX_DIM-1:0][MAX_DIM-1:0] solution;
    logic [DIM_W-1:0]                rows;
    logic [DIM_W-1:0]                cols;
    logic                            tx;
    logic                            done;
    logic                            dim_error;

    logic [MAX_DIM-1:0][MAX_DIM-1:0] grid;
    integer                          seed = 32'h110c;
    int                              errors = 0;
    int                              byte_count = 0;
    logic                            rx_active = 1'b0;
    logic [15:0]                     rec_q[$];
    record_t                         exp_q[$];

    `include "uart_rx_model.svh"

    board_uplink_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .solution  (solution),
        .rows      (rows),
        .cols      (cols),
        .tx        (tx),
        .done      (done),
        .dim_error (dim_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fill_grid(input pattern_e pat);
        integer rnd;
        int     r;
        int     c;
        for (r = 0; r < MAX_DIM; r++) begin
            for (c = 0; c < MAX_DIM; c++) begin
                case (pat)
                    PAT_ONES: grid[r][c] = 1'b1;
                    PAT_CHECKER: grid[r][c] = ((r + c) % 2 == 0);
                    default: begin
                        rnd = $random(seed);
                        grid[r][c] = rnd[0];
                    end
                endcase
            end
        end
    endtask

    // Reference record stream, built from the record sequence rules
    task automatic build_expected(input int nrows, input int ncols,
                                  input logic [MAX_DIM-1:0][MAX_DIM-1:0] cells);
        record_t r;
        int      i;
        int      j;
        exp_q.delete();
        r.flag  = START_BOARD;
        r.index = IDX_W'(nrows * 16 + ncols);
        r.value = 1'b0;
        exp_q.push_back(r);
        for (i = 0; i < nrows; i++) begin
            r.flag  = START_LINE;
            r.index = IDX_W'(i);
            r.value = 1'b0;
            exp_q.push_back(r);
            for (j = 0; j < ncols; j++) begin
                r.flag  = AND;
                r.index = IDX_W'(j);
                r.value = cells[i][j];
                exp_q.push_back(r);
            end
            r.flag  = END_LINE;
            r.index = IDX_W'(i);
            r.value = 1'b0;
            exp_q.push_back(r);
        end
        r.flag  = END_BOARD;
        r.index = '0;
        r.value = 1'b0;
        exp_q.push_back(r);
    endtask

    task automatic wait_done(input logic level, input int max_cycles, output bit ok);
        int k;
        ok = 1'b0;
        for (k = 0; k < max_cycles && !ok; k++) begin
            @(negedge clk);
            if (done === level) begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic pulse_load(input logic [MAX_DIM-1:0][MAX_DIM-1:0] cells,
                              input logic [DIM_W-1:0] r, input logic [DIM_W-1:0] c);
        @(posedge clk);
        #DRV_DELAY;
        rows     = r;
        cols     = c;
        solution = cells;
        load     = 1'b1;
        @(posedge clk);
        #DRV_DELAY;
        load = 1'b0; // dim_error for this load is visible now
    endtask

    task automatic compare_records(input int n);
        int i;
        if (rec_q.size() != exp_q.size()) begin
            $display("Entry %0d expected %0d records but received %0d", n, exp_q.size(),
                     rec_q.size());
            errors++;
        end
        for (i = 0; i < rec_q.size() && i < exp_q.size(); i++) begin
            if (rec_q[i] !== exp_q[i]) begin
                $display("[FAIL] record[%0d] expected %h got %h", i, exp_q[i], rec_q[i]);
                errors++;
            end
        end
    endtask

    task automatic run_entry(input int n, output bit good);
        entry_t e;
        int     errs_before;
        int     nrec;
        bit     ok;
        e = entries[n];
        errs_before = errors;
        if (rec_q.size() != 0 || byte_count != 0 || rx_active) begin
            $display("Bytes appeared on tx without a valid load before entry %0d", n);
            errors++;
        end
        rec_q.delete();
        byte_count = 0;
        fill_grid(e.pattern);
        pulse_load(grid, e.rows, e.cols);
        if (e.err) begin
            if (dim_error !== 1'b1) begin
                $display("[FAIL] dim_error expected %h got %h", 1'b1, dim_error);
                errors++;
            end
            repeat (12 * CLKS_PER_BIT) @(negedge clk);
            if (done !== 1'b1) begin
                $display("[FAIL] done expected %h got %h", 1'b1, done);
                errors++;
            end
        end else begin
            if (dim_error !== 1'b0) begin
                $display("[FAIL] dim_error expected %h got %h", 1'b0, dim_error);
                errors++;
            end
            build_expected(int'(e.rows), int'(e.cols), grid);
            wait_done(1'b0, 10, ok);
            if (!ok) begin
                $display("done did not fall after a valid load in entry %0d", n);
                errors++;
            end
            if (ok && e.overlap) begin
                pulse_load(~grid, e.rows, e.cols); // Must be dropped
                if (dim_error !== 1'b0) begin
                    $display("[FAIL] dim_error expected %h got %h", 1'b0, dim_error);
                    errors++;
                end
            end
            nrec = exp_q.size();
            wait_done(1'b1, nrec * 20 * CLKS_PER_BIT * 3 / 2 + 50, ok);
            if (!ok) begin
                $display("done did not rise at the end of entry %0d", n);
                errors++;
            end
            if (rx_active) begin
                $display("done rose while a byte was still on the line");
                errors++;
            end
            if (byte_count % 2 != 0) begin
                $display("A byte is missing, odd number of bytes received");
                errors++;
            end
            compare_records(n);
            rec_q.delete(); // Anything received from here on is unexpected
            byte_count = 0;
        end
        good = (errors == errs_before);
        $display("entry %0d (%0dx%0d) %s", n, e.rows, e.cols, good ? "ok" : "bad");
    endtask

    // Watchdog sized from the table
    initial begin
        longint limit;
        int     k;
        int     nrec;
        limit = 20 * CLK_PERIOD;
        for (k = 0; k < N_ENTRIES; k++) begin
            if (entries[k].err) begin
                nrec = 2;
            end else begin
                nrec = 2 + int'(entries[k].rows) * (int'(entries[k].cols) + 2);
            end
            limit += longint'(nrec * 20 * CLKS_PER_BIT * CLK_PERIOD);
            limit += longint'((20 * CLKS_PER_BIT + 20) * CLK_PERIOD);
        end
        limit = limit * 3 / 2;
        #(limit);
        $display("Watchdog expired after %0d ns, run stopped", limit);
        $display("test failed");
        $finish;
    end

    initial begin
        int n;
        int ok_count;
        int bad_count;
        bit good;
        ok_count  = 0;
        bad_count = 0;
        rst       = 1'b1;
        load      = 1'b0;
        solution  = '0;
        rows      = '0;
        cols      = '0;
        repeat (10) @(posedge clk);
        #DRV_DELAY;
        rst = 1'b0;
        fork
            collect_records();
        join_none
        @(negedge clk);
        if (done !== 1'b1 || tx !== 1'b1 || dim_error !== 1'b0) begin
            $display("[FAIL] done/tx/dim_error expected %h got %h", 3'b110,
                     {done, tx, dim_error});
            errors++;
            bad_count++;
        end else begin
            ok_count++;
        end
        $display("reset values %s", (errors == 0) ? "ok" : "bad");
        for (n = 0; n < N_ENTRIES; n++) begin
            run_entry(n, good);
            if (good) begin
                ok_count++;
            end else begin
                bad_count++;
            end
        end
        $display("summary: %0d ok, %0d bad, %0d check errors", ok_count, bad_count, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/board_uplink_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_uplink_top #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                                                          clk,
    input  logic                                                          rst,
    input  logic                                                          load,
    input  logic [board_uplink_pkg::MAX_DIM-1:0][board_uplink_pkg::MAX_DIM-1:0] solution,
    input  logic [board_uplink_pkg::DIM_W-1:0]                           rows,
    input  logic [board_uplink_pkg::DIM_W-1:0]                           cols,
    output logic                                                          tx,
    output logic                                                          done,
    output logic                                                          dim_error
);

    import board_uplink_pkg::*;

    board_t     board;
    logic       start;
    logic       busy;
    logic [7:0] byte_data;
    logic       byte_strobe;

    board_capture capture_i (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .solution  (solution),
        .rows      (rows),
        .cols      (cols),
        .idle      (done),      // One board in flight at a time
        .board     (board),
        .start     (start),
        .dim_error (dim_error)
    );

    record_framer framer_i (
        .clk         (clk),
        .rst         (rst),
        .board       (board),
        .start       (start),
        .busy        (busy),
        .byte_data   (byte_data),
        .byte_strobe (byte_strobe),
        .done        (done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_i (
        .clk         (clk),
        .rst         (rst),
        .byte_data   (byte_data),
        .byte_strobe (byte_strobe),
        .busy        (busy),
        .tx          (tx)
    );

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] byte_data,
    input  logic       byte_strobe,
    output logic       busy,
    output logic       tx
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [CNT_W-1:0] clk_cnt;  // Position inside one bit period
    logic [3:0]       bit_cnt;  // 0 is start bit, 9 is stop bit
    logic [8:0]       shreg;    // Data bits then stop bit
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            tx      <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (byte_strobe) begin
                busy    <= 1'b1;
                tx      <= 1'b0; // Start bit
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
                tx   <= 1'b1;
            end else begin
                tx      <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // LSB first, ones shift in behind the stop bit
    always_ff @(posedge clk) begin
        if (!busy && byte_strobe) begin
            shreg <= {1'b1, byte_data};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

    busy_after_strobe: assert property (
        @(posedge clk) disable iff (rst)
        byte_strobe |=> busy
    ) else $error("busy did not follow byte strobe");

endmodule

`default_nettype wire

// File: hw/record_framer.sv
`timescale 1ns/1ps
`default_nettype none

module record_framer (
    input  logic                     clk,
    input  logic                     rst,
    input  board_uplink_pkg::board_t board,
    input  logic                     start,
    input  logic                     busy,
    output logic [7:0]               byte_data,
    output logic                     byte_strobe,
    output logic                     done
);

    import board_uplink_pkg::*;

    framer_state_e    state;
    logic [DIM_W-1:0] row_cnt;
    logic [DIM_W-1:0] col_cnt;
    logic             half;    // Low byte of the current record is next
    logic             gap;     // Wait cycle after each strobe
    record_t          rec;
    logic             last_col;
    logic             last_row;
    logic             can_send;

    assign last_col = (col_cnt == board.cols - 1'b1);
    assign last_row = (row_cnt == board.rows - 1'b1);
    assign can_send = !gap && !busy;

    // Record for the current state
    always_comb begin
        rec.flag  = START_BOARD;
        rec.index = '0;
        rec.value = 1'b0;
        case (state)
            IDLE, HEADER: begin
                rec.flag  = START_BOARD;
                rec.index = IDX_W'({board.rows, board.cols});
            end
            LINE_OPEN: begin
                rec.flag  = START_LINE;
                rec.index = IDX_W'(row_cnt);
            end
            CELL: begin
                rec.flag  = AND;
                rec.index = IDX_W'(col_cnt);
                rec.value = board.cells[row_cnt][col_cnt];
            end
            LINE_CLOSE: begin
                rec.flag  = END_LINE;
                rec.index = IDX_W'(row_cnt);
            end
            TRAILER: begin
                rec.flag  = END_BOARD;
            end
            default: begin
                rec.flag  = END_BOARD;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            row_cnt     <= '0;
            col_cnt     <= '0;
            half        <= 1'b0;
            gap         <= 1'b0;
            byte_strobe <= 1'b0;
            done        <= 1'b1;
        end else begin
            byte_strobe <= 1'b0;
            gap         <= 1'b0;

            if (state == IDLE) begin
                if (start) begin
                    // Header high byte goes out right away
                    byte_strobe <= 1'b1;
                    gap         <= 1'b1;
                    half        <= 1'b1;
                    row_cnt     <= '0;
                    col_cnt     <= '0;
                    done        <= 1'b0;
                    state       <= HEADER;
                end else if (!done && can_send) begin
                    done <= 1'b1; // Last stop bit has left the line
                end
            end else if (can_send) begin
                byte_strobe <= 1'b1;
                gap         <= 1'b1;
                half        <= !half;

                if (half) begin
                    // Low byte leaves now, step to the next record
                    case (state)
                        HEADER: begin
                            state <= LINE_OPEN;
                        end
                        LINE_OPEN: begin
                            col_cnt <= '0;
                            state   <= CELL;
                        end
                        CELL: begin
                            if (last_col) begin
                                state <= LINE_CLOSE;
                            end else begin
                                col_cnt <= col_cnt + 1'b1;
                            end
                        end
                        LINE_CLOSE: begin
                            if (last_row) begin
                                state <= TRAILER;
                            end else begin
                                row_cnt <= row_cnt + 1'b1;
                                state   <= LINE_OPEN;
                            end
                        end
                        TRAILER: begin
                            state <= IDLE; // done waits for busy to drop
                        end
                        default: begin
                            state <= IDLE;
                        end
                    endcase
                end
            end
        end
    end

    // Byte lane follows the half flag at strobe time
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            byte_data <= rec[15:8];
        end else if (can_send) begin
            byte_data <= half ? rec[7:0] : rec[15:8];
        end
    end

    // The transmitter drops any byte offered during a frame
    no_strobe_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        byte_strobe |-> !busy
    ) else $error("byte strobe while transmitter busy");

endmodule

`default_nettype wire

// File: hw/board_capture.sv
`timescale 1ns/1ps
`default_nettype none

module board_capture (
    input  logic                                                          clk,
    input  logic                                                          rst,
    input  logic                                                          load,
    input  logic [board_uplink_pkg::MAX_DIM-1:0][board_uplink_pkg::MAX_DIM-1:0] solution,
    input  logic [board_uplink_pkg::DIM_W-1:0]                           rows,
    input  logic [board_uplink_pkg::DIM_W-1:0]                           cols,
    input  logic                                                          idle,
    output board_uplink_pkg::board_t                                      board,
    output logic                                                          start,
    output logic                                                          dim_error
);

    import board_uplink_pkg::*;

    logic rows_ok;
    logic cols_ok;
    logic dims_ok;
    logic accept;

    // Both sides must be within 1..MAX_DIM
    assign rows_ok = (rows != '0) && (rows <= DIM_W'(MAX_DIM));
    assign cols_ok = (cols != '0) && (cols <= DIM_W'(MAX_DIM));
    assign dims_ok = rows_ok && cols_ok;

    // Loads during a transfer are dropped without any report
    assign accept = load && idle && dims_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            start     <= 1'b0;
            dim_error <= 1'b0;
        end else begin
            start     <= accept;
            dim_error <= load && idle && !dims_ok;
        end
    end

    // Snapshot, so the solver is free to move on
    always_ff @(posedge clk) begin
        if (accept) begin
            board.rows  <= rows;
            board.cols  <= cols;
            board.cells <= solution;
        end
    end

    // The framer must still report done when the start pulse reaches it
    start_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        start |-> idle
    ) else $error("start issued while framer busy");

endmodule

`default_nettype wire

// File: hw/board_uplink_pkg.sv
`default_nettype none

package board_uplink_pkg;

    localparam int MAX_DIM = 11; // Largest board side
    localparam int DIM_W = 4;    // Width of a row or column count
    localparam int IDX_W = 12;   // Record index field

    // Record flags as seen by the host
    typedef enum logic [2:0] {
        START_BOARD = 3'b111,
        START_LINE  = 3'b110,
        AND         = 3'b101, // One cell
        END_LINE    = 3'b001,
        END_BOARD   = 3'b000
    } msg_flag_e;

    // One record, sent high byte first
    typedef struct packed {
        msg_flag_e        flag;
        logic [IDX_W-1:0] index;
        logic             value;
    } record_t;

    // Snapshot of a solved board, cell r,c is cells[r][c]
    typedef struct packed {
        logic [DIM_W-1:0]                rows;
        logic [DIM_W-1:0]                cols;
        logic [MAX_DIM-1:0][MAX_DIM-1:0] cells;
    } board_t;

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        LINE_OPEN,
        CELL,
        LINE_CLOSE,
        TRAILER
    } framer_state_e;

endpackage

`default_nettype wire
